//--- design/trace_pkg.sv
//////////////////////////////
// shared widths, stage indices and slot payloads of the trace unit
// every design file refers to these by scoped name
//////////////////////////////

package trace_pkg;

    //////////////////////////////
    // widths and depths
    //////////////////////////////

    // trace id, one per accepted fetch, wraps at ID_DEPTH
    localparam int ID_W = 6;
    localparam int ID_DEPTH = 64;

    // free running cycle stamp, wraps
    localparam int STAMP_W = 16;

    // instruction word and the opcode field at its low end
    localparam int INSTR_W = 32;
    localparam int OPC_W = 7;

    // stall cycle count, saturates at all ones
    localparam int STALL_W = 8;

    // configuration port
    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 16;

    // configuration register map
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_ENABLE = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MASK = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_VALUE = 2'd2;

    //////////////////////////////
    // pipeline stages
    //////////////////////////////

    // fetch, decode, execute, memory, write-back
    localparam int NUM_STAGES = 5;
    localparam int ST_F = 0;
    localparam int ST_D = ST_F + 1;
    localparam int ST_E = ST_F + 2;
    localparam int ST_M = ST_F + 3;
    localparam int ST_W = NUM_STAGES - 1;

    //////////////////////////////
    // slot payloads
    //////////////////////////////

    // written in the fetch accept cycle, 48 bits
    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        logic [STAMP_W-1:0] fetch_stamp;
    } fetch_slot_t;

    // written on the decode to execute move, 40 bits
    typedef struct packed {
        logic [STAMP_W-1:0] decode_stamp;
        logic [STAMP_W-1:0] exec_stamp;
        logic [STALL_W-1:0] stall_cycles;
    } issue_slot_t;

endpackage

//--- design/trace_cfg_regs.sv
//////////////////////////////
// configuration registers of the trace unit, written by a single strobe
// enable at address 0, opcode mask at 1, opcode value at 2
//////////////////////////////

`timescale 1ns/1ps

module trace_cfg_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cfg_strobe,
    input  logic [trace_pkg::CFG_ADDR_W-1:0]    cfg_addr,
    input  logic [trace_pkg::CFG_DATA_W-1:0]    cfg_wdata,
    output logic                                trace_enable,
    output logic [trace_pkg::OPC_W-1:0]         opc_mask,
    output logic [trace_pkg::OPC_W-1:0]         opc_value
);

    // one write enable per register
    logic wr_enable;
    logic wr_mask;
    logic wr_value;

    assign wr_enable = cfg_strobe && (cfg_addr == trace_pkg::CFG_ADDR_ENABLE);
    assign wr_mask = cfg_strobe && (cfg_addr == trace_pkg::CFG_ADDR_MASK);
    assign wr_value = cfg_strobe && (cfg_addr == trace_pkg::CFG_ADDR_VALUE);

    // address 3 is not mapped, writes there are dropped
    // new values are seen by the reporter from the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            // tracing off, filter passes every opcode
            trace_enable <= 1'b0;
            opc_mask <= '0;
            opc_value <= '0;
        end else begin
            if (wr_enable) begin
                trace_enable <= cfg_wdata[0];
            end
            if (wr_mask) begin
                opc_mask <= cfg_wdata[trace_pkg::OPC_W-1:0];
            end
            if (wr_value) begin
                opc_value <= cfg_wdata[trace_pkg::OPC_W-1:0];
            end
        end
    end

endmodule

//--- design/stage_tag_pipe.sv
//////////////////////////////
// follows trace ids through the five pipeline stages under stall and flush
// keeps the cycle counter and raises the slot store write strobes
//////////////////////////////

`timescale 1ns/1ps

module stage_tag_pipe (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fetch_strobe,
    input  logic                            stall,
    input  logic                            flush,
    output logic                            fetch_wr,
    output logic [trace_pkg::ID_W-1:0]      fetch_wr_id,
    output logic [trace_pkg::STAMP_W-1:0]   fetch_stamp,
    output logic                            issue_wr,
    output logic [trace_pkg::ID_W-1:0]      issue_wr_id,
    output logic [trace_pkg::STAMP_W-1:0]   decode_stamp,
    output logic [trace_pkg::STAMP_W-1:0]   exec_stamp,
    output logic [trace_pkg::STALL_W-1:0]   stall_cycles,
    output logic                            wb_valid,
    output logic [trace_pkg::ID_W-1:0]      wb_id,
    output logic [trace_pkg::STAMP_W-1:0]   wb_stamp
);

    //////////////////////////////
    // state
    //////////////////////////////

    // cycle counter, 0 in the first cycle out of reset
    logic [trace_pkg::STAMP_W-1:0] cycle_cnt;
    logic [trace_pkg::STAMP_W-1:0] stamp_next;

    // id handed to the next accepted fetch
    logic [trace_pkg::ID_W-1:0] next_id;

    // the fetch stage is the accept cycle itself,
    // decode through write-back are registered
    logic [trace_pkg::ST_W:trace_pkg::ST_D] vld_q;
    logic [trace_pkg::ID_W-1:0] id_q [trace_pkg::ST_D:trace_pkg::ST_W];

    // decode entry stamp and stall count of the decode instruction
    logic [trace_pkg::STAMP_W-1:0] dec_stamp_q;
    logic [trace_pkg::STALL_W-1:0] stall_cnt_q;

    // stage moves for this cycle
    logic fetch_acc;
    logic issue_go;

    // flush wins over stall, both block a new fetch
    assign fetch_acc = fetch_strobe && !stall && !flush;
    // decode moves on only when neither stall nor flush is up
    assign issue_go = vld_q[trace_pkg::ST_D] && !stall && !flush;
    // the cycle after this one
    assign stamp_next = cycle_cnt + 1'b1;

    //////////////////////////////
    // counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= stamp_next;
        end
    end

    // wraps past ID_DEPTH-1 by width
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
        end else if (fetch_acc) begin
            next_id <= next_id + 1'b1;
        end
    end

    //////////////////////////////
    // stage valid bits
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            // flush empties decode, stall holds it
            if (flush) begin
                vld_q[trace_pkg::ST_D] <= 1'b0;
            end else if (!stall) begin
                vld_q[trace_pkg::ST_D] <= fetch_acc;
            end
            // a stall or flush puts a bubble into execute
            vld_q[trace_pkg::ST_E] <= issue_go;
            // memory and write-back always advance
            for (int s = trace_pkg::ST_M; s <= trace_pkg::ST_W; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    //////////////////////////////
    // ids, decode stamp and stall count
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!stall) begin
            // new decode entry, first decode cycle is the next one
            id_q[trace_pkg::ST_D] <= next_id;
            dec_stamp_q <= stamp_next;
            stall_cnt_q <= '0;
        end else if (vld_q[trace_pkg::ST_D] && !flush && (stall_cnt_q != '1)) begin
            // held in decode, count the lost cycle and saturate
            stall_cnt_q <= stall_cnt_q + 1'b1;
        end
        // the id moves along, the valid bits say whether it counts
        id_q[trace_pkg::ST_E] <= id_q[trace_pkg::ST_D];
        for (int s = trace_pkg::ST_M; s <= trace_pkg::ST_W; s++) begin
            id_q[s] <= id_q[s-1];
        end
    end

    //////////////////////////////
    // write strobes and write-back view
    //////////////////////////////

    // fetch slot is written in the accept cycle
    assign fetch_wr = fetch_acc;
    assign fetch_wr_id = next_id;
    assign fetch_stamp = cycle_cnt;

    // issue slot is written on the decode to execute move,
    // execute starts in the next cycle
    assign issue_wr = issue_go;
    assign issue_wr_id = id_q[trace_pkg::ST_D];
    assign decode_stamp = dec_stamp_q;
    assign exec_stamp = stamp_next;
    assign stall_cycles = stall_cnt_q;

    // retire stamp is the record cycle, one after write-back
    assign wb_valid = vld_q[trace_pkg::ST_W];
    assign wb_id = id_q[trace_pkg::ST_W];
    assign wb_stamp = stamp_next;

endmodule

//--- design/trace_slot_ram.sv
//////////////////////////////
// id-indexed slot store, one write and one registered read port
// the payload type is chosen per instance
//////////////////////////////

`timescale 1ns/1ps

module trace_slot_ram #(
    parameter type payload_t = trace_pkg::fetch_slot_t
) (
    input  logic                        clk,
    input  logic                        wr,
    input  logic [trace_pkg::ID_W-1:0]  wr_id,
    input  payload_t                    wr_data,
    input  logic [trace_pkg::ID_W-1:0]  rd_id,
    output payload_t                    rd_data
);

    // one slot per trace id
    payload_t mem [trace_pkg::ID_DEPTH];

    // slots of flushed ids are simply overwritten
    // when the id comes round again
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_id] <= wr_data;
        end
    end

    // read data is valid the cycle after rd_id,
    // ids in flight never collide with the write id
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_id];
    end

endmodule

//--- design/retire_reporter.sv
//////////////////////////////
// reads both slot stores at write-back and emits one trace record
// per retiring instruction that passes the enable and opcode filter
//////////////////////////////

`timescale 1ns/1ps

module retire_reporter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wb_valid,
    input  logic [trace_pkg::ID_W-1:0]      wb_id,
    input  logic [trace_pkg::STAMP_W-1:0]   wb_stamp,
    input  logic                            trace_enable,
    input  logic [trace_pkg::OPC_W-1:0]     opc_mask,
    input  logic [trace_pkg::OPC_W-1:0]     opc_value,
    output logic [trace_pkg::ID_W-1:0]      fetch_rd_id,
    output logic [trace_pkg::ID_W-1:0]      issue_rd_id,
    input  trace_pkg::fetch_slot_t          fetch_rd_data,
    input  trace_pkg::issue_slot_t          issue_rd_data,
    output logic                            rec_strobe,
    output logic [trace_pkg::ID_W-1:0]      rec_id,
    output logic [trace_pkg::INSTR_W-1:0]   rec_instr,
    output logic [trace_pkg::STAMP_W-1:0]   rec_fetch_stamp,
    output logic [trace_pkg::STAMP_W-1:0]   rec_decode_stamp,
    output logic [trace_pkg::STAMP_W-1:0]   rec_exec_stamp,
    output logic [trace_pkg::STALL_W-1:0]   rec_stall_cycles,
    output logic [trace_pkg::STAMP_W-1:0]   rec_retire_stamp
);

    // write-back view delayed to meet the store read data
    logic                           rpt_vld_q;
    logic [trace_pkg::ID_W-1:0]     rpt_id_q;
    logic [trace_pkg::STAMP_W-1:0]  rpt_stamp_q;

    // opcode filter result
    logic opc_match;

    // both stores are read with the write-back id
    assign fetch_rd_id = wb_id;
    assign issue_rd_id = wb_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            rpt_vld_q <= 1'b0;
        end else begin
            rpt_vld_q <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        rpt_id_q <= wb_id;
        rpt_stamp_q <= wb_stamp;
    end

    // a zero mask passes every opcode
    assign opc_match = ((fetch_rd_data.instr[trace_pkg::OPC_W-1:0] & opc_mask)
                        == (opc_value & opc_mask));

    //////////////////////////////
    // trace record
    //////////////////////////////

    // single cycle strobe, no back-pressure
    assign rec_strobe = rpt_vld_q && trace_enable && opc_match;

    assign rec_id = rpt_id_q;
    assign rec_instr = fetch_rd_data.instr;
    assign rec_fetch_stamp = fetch_rd_data.fetch_stamp;
    assign rec_decode_stamp = issue_rd_data.decode_stamp;
    assign rec_exec_stamp = issue_rd_data.exec_stamp;
    assign rec_stall_cycles = issue_rd_data.stall_cycles;
    // equals the strobe cycle
    assign rec_retire_stamp = rpt_stamp_q;

endmodule

//--- design/trace_unit_top.sv
//////////////////////////////
// top level of the instruction trace unit
// connects config block, tag pipe, both slot stores and the reporter
//////////////////////////////

`timescale 1ns/1ps

module trace_unit_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cfg_strobe,
    input  logic [trace_pkg::CFG_ADDR_W-1:0]    cfg_addr,
    input  logic [trace_pkg::CFG_DATA_W-1:0]    cfg_wdata,
    input  logic                                fetch_strobe,
    input  logic [trace_pkg::INSTR_W-1:0]       fetch_instr,
    input  logic                                stall,
    input  logic                                flush,
    output logic                                rec_strobe,
    output logic [trace_pkg::ID_W-1:0]          rec_id,
    output logic [trace_pkg::INSTR_W-1:0]       rec_instr,
    output logic [trace_pkg::STAMP_W-1:0]       rec_fetch_stamp,
    output logic [trace_pkg::STAMP_W-1:0]       rec_decode_stamp,
    output logic [trace_pkg::STAMP_W-1:0]       rec_exec_stamp,
    output logic [trace_pkg::STALL_W-1:0]       rec_stall_cycles,
    output logic [trace_pkg::STAMP_W-1:0]       rec_retire_stamp
);

    // configuration
    logic                           trace_enable;
    logic [trace_pkg::OPC_W-1:0]    opc_mask;
    logic [trace_pkg::OPC_W-1:0]    opc_value;

    // tag pipe to slot stores and reporter
    logic                           fetch_wr;
    logic [trace_pkg::ID_W-1:0]     fetch_wr_id;
    logic [trace_pkg::STAMP_W-1:0]  fetch_stamp;
    logic                           issue_wr;
    logic [trace_pkg::ID_W-1:0]     issue_wr_id;
    logic [trace_pkg::STAMP_W-1:0]  decode_stamp;
    logic [trace_pkg::STAMP_W-1:0]  exec_stamp;
    logic [trace_pkg::STALL_W-1:0]  stall_cycles;
    logic                           wb_valid;
    logic [trace_pkg::ID_W-1:0]     wb_id;
    logic [trace_pkg::STAMP_W-1:0]  wb_stamp;

    // slot store payloads and read ids
    trace_pkg::fetch_slot_t         fetch_wr_data;
    trace_pkg::fetch_slot_t         fetch_rd_data;
    trace_pkg::issue_slot_t         issue_wr_data;
    trace_pkg::issue_slot_t         issue_rd_data;
    logic [trace_pkg::ID_W-1:0]     fetch_rd_id;
    logic [trace_pkg::ID_W-1:0]     issue_rd_id;

    assign fetch_wr_data = '{instr: fetch_instr, fetch_stamp: fetch_stamp};
    assign issue_wr_data = '{decode_stamp: decode_stamp, exec_stamp: exec_stamp,
                             stall_cycles: stall_cycles};

    trace_cfg_regs u_cfg (
        .clk(clk), .rst(rst), .cfg_strobe(cfg_strobe), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .trace_enable(trace_enable), .opc_mask(opc_mask),
        .opc_value(opc_value)
    );

    stage_tag_pipe u_pipe (
        .clk(clk), .rst(rst), .fetch_strobe(fetch_strobe), .stall(stall), .flush(flush),
        .fetch_wr(fetch_wr), .fetch_wr_id(fetch_wr_id), .fetch_stamp(fetch_stamp),
        .issue_wr(issue_wr), .issue_wr_id(issue_wr_id), .decode_stamp(decode_stamp),
        .exec_stamp(exec_stamp), .stall_cycles(stall_cycles), .wb_valid(wb_valid),
        .wb_id(wb_id), .wb_stamp(wb_stamp)
    );

    // instruction word and fetch stamp per id
    trace_slot_ram #(.payload_t(trace_pkg::fetch_slot_t)) u_fetch_ram (
        .clk(clk), .wr(fetch_wr), .wr_id(fetch_wr_id), .wr_data(fetch_wr_data),
        .rd_id(fetch_rd_id), .rd_data(fetch_rd_data)
    );

    // decode and execute stamps and stall count per id
    trace_slot_ram #(.payload_t(trace_pkg::issue_slot_t)) u_issue_ram (
        .clk(clk), .wr(issue_wr), .wr_id(issue_wr_id), .wr_data(issue_wr_data),
        .rd_id(issue_rd_id), .rd_data(issue_rd_data)
    );

    retire_reporter u_rpt (
        .clk(clk), .rst(rst), .wb_valid(wb_valid), .wb_id(wb_id), .wb_stamp(wb_stamp),
        .trace_enable(trace_enable), .opc_mask(opc_mask), .opc_value(opc_value),
        .fetch_rd_id(fetch_rd_id), .issue_rd_id(issue_rd_id),
        .fetch_rd_data(fetch_rd_data), .issue_rd_data(issue_rd_data),
        .rec_strobe(rec_strobe), .rec_id(rec_id), .rec_instr(rec_instr),
        .rec_fetch_stamp(rec_fetch_stamp), .rec_decode_stamp(rec_decode_stamp),
        .rec_exec_stamp(rec_exec_stamp), .rec_stall_cycles(rec_stall_cycles),
        .rec_retire_stamp(rec_retire_stamp)
    );

endmodule

//--- tests/trace_checker.sv
//////////////////////////////
// trace record checker on the DUT record port
// compares every strobe against the queue of expected records in order
//////////////////////////////

`timescale 1ns/1ps

module trace_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rec_strobe,
    input  logic [trace_pkg::ID_W-1:0]      rec_id,
    input  logic [trace_pkg::INSTR_W-1:0]   rec_instr,
    input  logic [trace_pkg::STAMP_W-1:0]   rec_fetch_stamp,
    input  logic [trace_pkg::STAMP_W-1:0]   rec_decode_stamp,
    input  logic [trace_pkg::STAMP_W-1:0]   rec_exec_stamp,
    input  logic [trace_pkg::STALL_W-1:0]   rec_stall_cycles,
    input  logic [trace_pkg::STAMP_W-1:0]   rec_retire_stamp
);

    // packed record of id instr fetch decode exec stall and retire
    logic [109:0] exp_q [$];

    int error_count = 0;
    int checked_count = 0;

    // unpacked head of the queue
    logic [5:0]  e_id;
    logic [31:0] e_instr;
    logic [15:0] e_fetch;
    logic [15:0] e_decode;
    logic [15:0] e_exec;
    logic [7:0]  e_stall;
    logic [15:0] e_retire;

    function automatic void push_record(input logic [5:0] id, input logic [31:0] instr,
                                        input logic [15:0] fetch, input logic [15:0] decode,
                                        input logic [15:0] exec, input logic [7:0] stall,
                                        input logic [15:0] retire);
        exp_q.push_back({id, instr, fetch, decode, exec, stall, retire});
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    // used after a timeout so that later tests start clean
    task automatic drop_pending();
        exp_q.delete();
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    //////////////////////////////
    // sampled at the rising edge before the DUT registers update
    //////////////////////////////

    always @(posedge clk) begin
        if (!rst && rec_strobe === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("a trace record with id %h came out but none was expected", rec_id);
                error_count++;
            end else begin
                {e_id, e_instr, e_fetch, e_decode, e_exec, e_stall, e_retire} =
                    exp_q.pop_front();
                compare_field("rec_id", 32'(rec_id), 32'(e_id));
                compare_field("rec_instr", rec_instr, e_instr);
                compare_field("rec_fetch_stamp", 32'(rec_fetch_stamp), 32'(e_fetch));
                compare_field("rec_decode_stamp", 32'(rec_decode_stamp), 32'(e_decode));
                compare_field("rec_exec_stamp", 32'(rec_exec_stamp), 32'(e_exec));
                compare_field("rec_stall_cycles", 32'(rec_stall_cycles), 32'(e_stall));
                compare_field("rec_retire_stamp", 32'(rec_retire_stamp), 32'(e_retire));
                checked_count++;
            end
        end
    end

endmodule

//--- tests/tb_trace_unit.sv
//////////////////////////////
// testbench of the trace unit, runs the tests listed in the vector file
// random cycles are checked against a reference pipeline model
//////////////////////////////

`timescale 1ns/1ps

module tb_trace_unit;

    logic clk;
    logic rst;
    logic cfg_strobe;
    logic [1:0] cfg_addr;
    logic [15:0] cfg_wdata;
    logic fetch_strobe;
    logic [31:0] fetch_instr;
    logic stall;
    logic flush;
    logic rec_strobe;
    logic [5:0] rec_id;
    logic [31:0] rec_instr;
    logic [15:0] rec_fetch_stamp;
    logic [15:0] rec_decode_stamp;
    logic [15:0] rec_exec_stamp;
    logic [7:0] rec_stall_cycles;
    logic [15:0] rec_retire_stamp;

    // run state
    int cyc;
    int seed;
    int timeouts;
    int bad_lines;
    int test_num;
    int tests_run;
    int tests_failed;
    int errs_before;
    logic open_failed;
    logic gen;

    //////////////////////////////
    // reference model of the tag pipe
    //////////////////////////////

    logic m_dv, m_ev, m_mv, m_wv;
    logic [5:0] m_did, m_eid, m_mid, m_wid, m_next;
    logic [15:0] m_dst;
    logic [7:0] m_dstl;
    logic m_en;
    logic [6:0] m_mask, m_val;
    logic [31:0] m_instr [64];
    logic [15:0] m_fst [64];
    logic [15:0] m_dsa [64];
    logic [15:0] m_est [64];
    logic [7:0] m_stl [64];

    trace_unit_top UUT (
        .clk(clk), .rst(rst), .cfg_strobe(cfg_strobe), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .fetch_strobe(fetch_strobe), .fetch_instr(fetch_instr),
        .stall(stall), .flush(flush), .rec_strobe(rec_strobe), .rec_id(rec_id),
        .rec_instr(rec_instr), .rec_fetch_stamp(rec_fetch_stamp),
        .rec_decode_stamp(rec_decode_stamp), .rec_exec_stamp(rec_exec_stamp),
        .rec_stall_cycles(rec_stall_cycles), .rec_retire_stamp(rec_retire_stamp)
    );

    trace_checker chk (
        .clk(clk), .rst(rst), .rec_strobe(rec_strobe), .rec_id(rec_id),
        .rec_instr(rec_instr), .rec_fetch_stamp(rec_fetch_stamp),
        .rec_decode_stamp(rec_decode_stamp), .rec_exec_stamp(rec_exec_stamp),
        .rec_stall_cycles(rec_stall_cycles), .rec_retire_stamp(rec_retire_stamp)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // mismatches, timeouts and malformed vector lines together
    function automatic int total_errors();
        return chk.error_count + timeouts + bad_lines;
    endfunction

    task automatic note_bad_line(input string kind);
        $display("the vector file holds a malformed %s line", kind);
        bad_lines++;
    endtask

    // one cycle of the model with c as the cycle stamp of the inputs
    function automatic void model_step(input logic [15:0] c, input logic cs,
                                       input logic [1:0] ca, input logic [15:0] cd,
                                       input logic fs, input logic [31:0] fi,
                                       input logic st, input logic fl, output logic acc);
        logic issue;
        // config writes take effect in the record cycle
        if (cs && ca == 2'd0) begin
            m_en = cd[0];
        end
        if (cs && ca == 2'd1) begin
            m_mask = cd[6:0];
        end
        if (cs && ca == 2'd2) begin
            m_val = cd[6:0];
        end
        if (m_wv && gen && m_en && (((m_instr[m_wid][6:0] ^ m_val) & m_mask) == 7'd0)) begin
            chk.push_record(m_wid, m_instr[m_wid], m_fst[m_wid], m_dsa[m_wid],
                            m_est[m_wid], m_stl[m_wid], c + 16'd1);
        end
        acc = fs && !st && !fl;
        issue = m_dv && !st && !fl;
        if (acc) begin
            m_instr[m_next] = fi;
            m_fst[m_next] = c;
        end
        if (issue) begin
            m_dsa[m_did] = m_dst;
            m_est[m_did] = c + 16'd1;
            m_stl[m_did] = m_dstl;
        end
        // memory and write-back always move and execute takes a bubble on stall
        m_wv = m_mv;
        m_wid = m_mid;
        m_mv = m_ev;
        m_mid = m_eid;
        m_ev = issue;
        m_eid = m_did;
        if (fl) begin
            m_dv = 1'b0;
        end else if (!st) begin
            m_dv = acc;
            m_did = m_next;
            m_dst = c + 16'd1;
            m_dstl = 8'd0;
        end else if (m_dv && m_dstl != 8'hff) begin
            m_dstl = m_dstl + 8'd1;
        end
        if (acc) begin
            m_next = m_next + 6'd1;
        end
    endfunction

    // drive on the falling edge and wait for the next one
    task automatic apply_cycle(input logic cs, input logic [1:0] ca, input logic [15:0] cd,
                               input logic fs, input logic [31:0] fi, input logic st,
                               input logic fl, output logic acc);
        cfg_strobe = cs;
        cfg_addr = ca;
        cfg_wdata = cd;
        fetch_strobe = fs;
        fetch_instr = fi;
        stall = st;
        flush = fl;
        model_step(cyc[15:0], cs, ca, cd, fs, fi, st, fl, acc);
        @(negedge clk);
        cyc++;
    endtask

    // idle until every record is out and the pipe is empty
    task automatic wait_records();
        int waited;
        logic acc;
        waited = 0;
        while ((chk.pending() > 0 || m_dv || m_ev || m_mv || m_wv) && waited < 50) begin
            apply_cycle(1'b0, 2'd0, 16'd0, 1'b0, 32'd0, 1'b0, 1'b0, acc);
            waited++;
        end
        if (chk.pending() > 0 || m_dv || m_ev || m_mv || m_wv) begin
            $display("timeout: test %0d still waits for trace records after 50 cycles",
                     test_num);
            timeouts++;
            chk.drop_pending();
        end
    endtask

    // seeded mix of fetches, stalls and flushes until count ids are taken
    task automatic run_random(input int count);
        int ids;
        int guard;
        logic [31:0] r;
        logic [31:0] instr;
        logic acc;
        ids = 0;
        guard = 0;
        gen = 1'b1;
        while (ids < count && guard < 2000) begin
            r = $random(seed);
            instr = $random(seed);
            apply_cycle(1'b0, 2'd0, 16'd0, r[1:0] != 2'b00, instr, r[4:2] == 3'b000,
                        r[7:5] == 3'b000, acc);
            if (acc) begin
                ids++;
            end
            guard++;
        end
        if (ids < count) begin
            $display("random test took only %0d of %0d ids in 2000 cycles", ids, count);
            timeouts++;
        end
    endtask

    // one token letter per line out of # T E C R W with numbers in hex
    task automatic run_vectors(input int fd);
        int ch;
        int code;
        logic done;
        logic acc;
        logic [8*128-1:0] line;
        logic [31:0] v0, v1, v2, v3, v4, v5, v6, v7;
        done = 1'b0;
        while (!done) begin
            ch = $fgetc(fd);
            if (ch < 0) begin
                done = 1'b1;
            end else begin
                case (8'(ch))
                    "#": code = $fgets(line, fd);
                    "T": begin
                        code = $fscanf(fd, "%h", v0);
                        test_num = v0;
                        errs_before = total_errors();
                        if (code != 1) begin
                            note_bad_line("T");
                        end
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                       v0, v1, v2, v3, v4, v5, v6);
                        if (code == 7) begin
                            chk.push_record(v0[5:0], v1, v2[15:0], v3[15:0], v4[15:0],
                                            v5[7:0], v6[15:0]);
                        end else begin
                            note_bad_line("E");
                        end
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                       v0, v1, v2, v3, v4, v5, v6, v7);
                        if (code == 8) begin
                            repeat (v0) begin
                                apply_cycle(v1[0], v2[1:0], v3[15:0], v4[0], v5, v6[0],
                                            v7[0], acc);
                            end
                        end else begin
                            note_bad_line("C");
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, "%h", v0);
                        if (code == 1) begin
                            run_random(v0);
                        end else begin
                            note_bad_line("R");
                        end
                    end
                    "W": begin
                        wait_records();
                        gen = 1'b0;
                        tests_run++;
                        if (total_errors() == errs_before) begin
                            $display("test %0d passed", test_num);
                        end else begin
                            tests_failed++;
                            $display("test %0d failed with %0d errors", test_num,
                                     total_errors() - errs_before);
                        end
                    end
                    default: ;
                endcase
            end
        end
    endtask

    initial begin
        int fd;
        rst = 1'b1;
        cfg_strobe = 1'b0;
        cfg_addr = 2'd0;
        cfg_wdata = 16'd0;
        fetch_strobe = 1'b0;
        fetch_instr = 32'd0;
        stall = 1'b0;
        flush = 1'b0;
        seed = 92;
        cyc = 0;
        timeouts = 0;
        bad_lines = 0;
        test_num = 0;
        tests_run = 0;
        tests_failed = 0;
        errs_before = 0;
        gen = 1'b0;
        open_failed = 1'b0;
        // model mirrors the reset state
        {m_dv, m_ev, m_mv, m_wv, m_en} = '0;
        {m_did, m_eid, m_mid, m_wid, m_next} = '0;
        m_dst = 16'd0;
        m_dstl = 8'd0;
        m_mask = 7'd0;
        m_val = 7'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("tests/trace_vectors.txt", "r");
        if (fd == 0) begin
            $display("the vector file tests/trace_vectors.txt could not be opened");
            open_failed = 1'b1;
        end else begin
            run_vectors(fd);
            $fclose(fd);
        end
        $display("%0d tests, %0d failed, %0d records checked, %0d errors", tests_run,
                 tests_failed, chk.checked_count, total_errors());
        if (!open_failed && tests_run > 0 && total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tests/trace_vectors.txt
# T test | E id instr fetch decode exec stall retire | R ids | W drain and report
# C count cfg_strobe cfg_addr cfg_wdata fetch_strobe fetch_instr stall flush, all hex
T 1
E 00 00000013 0001 0002 0003 00 0006
E 01 00000033 0002 0003 0004 00 0007
E 02 00000063 0003 0004 0005 00 0008
C 1 1 0 0001 0 00000000 0 0
C 1 0 0 0000 1 00000013 0 0
C 1 0 0 0000 1 00000033 0 0
C 1 0 0 0000 1 00000063 0 0
W
T 2
E 03 00100093 0009 000a 000b 00 000e
E 04 00200113 000a 000b 000c 00 000f
E 05 00300193 000b 000c 0010 03 0013
E 06 00400213 000f 0010 0011 00 0014
C 1 0 0 0000 1 00100093 0 0
C 1 0 0 0000 1 00200113 0 0
C 1 0 0 0000 1 00300193 0 0
C 1 0 0 0000 0 00000000 1 0
C 1 0 0 0000 1 deadbeef 1 0
C 1 0 0 0000 0 00000000 1 0
C 1 0 0 0000 1 00400213 0 0
W
T 3
E 07 00500293 0015 0016 0017 00 001a
E 09 00800413 0018 0019 001a 00 001d
C 1 0 0 0000 1 00500293 0 0
C 1 0 0 0000 1 00600313 0 0
C 1 0 0 0000 1 00700393 0 1
C 1 0 0 0000 1 00800413 0 0
W
T 4
E 0c 002081b3 0026 0027 0028 00 002b
E 0e 40208233 0028 0029 002a 00 002d
C 1 1 0 0000 0 00000000 0 0
C 1 0 0 0000 1 00000033 0 0
C 1 1 1 007f 0 00000000 0 0
C 1 1 2 0033 0 00000000 0 0
C 2 0 0 0000 0 00000000 0 0
C 1 1 0 0001 0 00000000 0 0
C 1 0 0 0000 1 00a00093 0 0
C 1 0 0 0000 1 002081b3 0 0
C 1 0 0 0000 1 00c00063 0 0
C 1 0 0 0000 1 40208233 0 0
W
T 5
C 1 1 1 0000 0 00000000 0 0
R 46
W

//--- build.f
design/trace_pkg.sv
design/trace_cfg_regs.sv
design/stage_tag_pipe.sv
design/trace_slot_ram.sv
design/retire_reporter.sv
design/trace_unit_top.sv
tests/trace_checker.sv
tests/tb_trace_unit.sv

//--- Makefile
# Verilator simulation of the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_unit
FLIST     ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
